//--- verilog/tap_ctrl_pkg.sv
// TAP controller definitions
// State encoding and next-state helpers shared by every TAP in the chain

`default_nettype none

package tap_ctrl_pkg;

    typedef enum logic [3:0] {
        ST_TLR, ST_RTI,
        ST_SEL_DR, ST_CAP_DR, ST_SHIFT_DR, ST_EXIT1_DR, ST_PAUSE_DR, ST_EXIT2_DR, ST_UPD_DR,
        ST_SEL_IR, ST_CAP_IR, ST_SHIFT_IR, ST_EXIT1_IR, ST_PAUSE_IR, ST_EXIT2_IR, ST_UPD_IR
    } tap_state_t;

    // Any state reaches Test-Logic-Reset after this many tms ones
    localparam int TLR_TMS_ONES = 5;

    // IEEE 1149.1 state diagram
    function automatic tap_state_t tap_next_state(tap_state_t s, logic tms);
        case (s)
            ST_TLR:      return tms ? ST_TLR      : ST_RTI;
            ST_RTI:      return tms ? ST_SEL_DR   : ST_RTI;
            ST_SEL_DR:   return tms ? ST_SEL_IR   : ST_CAP_DR;
            ST_CAP_DR:   return tms ? ST_EXIT1_DR : ST_SHIFT_DR;
            ST_SHIFT_DR: return tms ? ST_EXIT1_DR : ST_SHIFT_DR;
            ST_EXIT1_DR: return tms ? ST_UPD_DR   : ST_PAUSE_DR;
            ST_PAUSE_DR: return tms ? ST_EXIT2_DR : ST_PAUSE_DR;
            ST_EXIT2_DR: return tms ? ST_UPD_DR   : ST_SHIFT_DR;
            ST_UPD_DR:   return tms ? ST_SEL_DR   : ST_RTI;
            ST_SEL_IR:   return tms ? ST_TLR      : ST_CAP_IR;
            ST_CAP_IR:   return tms ? ST_EXIT1_IR : ST_SHIFT_IR;
            ST_SHIFT_IR: return tms ? ST_EXIT1_IR : ST_SHIFT_IR;
            ST_EXIT1_IR: return tms ? ST_UPD_IR   : ST_PAUSE_IR;
            ST_PAUSE_IR: return tms ? ST_EXIT2_IR : ST_PAUSE_IR;
            ST_EXIT2_IR: return tms ? ST_UPD_IR   : ST_SHIFT_IR;
            ST_UPD_IR:   return tms ? ST_SEL_DR   : ST_RTI;
            default:     return ST_TLR;
        endcase
    endfunction

    function automatic logic tap_is_shift(tap_state_t s);
        return (s == ST_SHIFT_DR) || (s == ST_SHIFT_IR);
    endfunction

endpackage

`default_nettype wire

//--- verilog/tap_instr_pkg.sv
// TAP instruction definitions
// Instruction width, opcodes, IDCODE type and the Capture-IR pattern

`default_nettype none

package tap_instr_pkg;

    localparam int IR_WIDTH = 4;

    typedef logic [IR_WIDTH-1:0] ir_t;

    // ------------------------------------------------------------------------
    // Opcodes
    // ------------------------------------------------------------------------
    localparam ir_t OP_IDCODE   = ir_t'(2);
    localparam ir_t OP_BYPASS   = '1;
    // Network select, decoded by the master only
    localparam ir_t OP_TAPNW_SEL = ir_t'(5);

    // Fixed 01 in the two low bits, as 1149.1 requires
    localparam ir_t IR_CAPTURE = ir_t'(2'b01);

    // Identification code, bit 0 is always 1
    typedef logic [31:0] idcode_t;

endpackage

`default_nettype wire

//--- verilog/tap_fsm.sv
// TAP controller
// Sixteen-state 1149.1 FSM with capture, shift and update strobes

`timescale 1ns/100ps
`default_nettype none

module tap_fsm (
    input  logic                     tck,
    input  logic                     rst_n,
    input  logic                     tms,
    output tap_ctrl_pkg::tap_state_t state,
    output logic                     capture_ir,
    output logic                     shift_ir,
    output logic                     update_ir,
    output logic                     capture_dr,
    output logic                     shift_dr,
    output logic                     update_dr
);
    import tap_ctrl_pkg::*;

    // One state per rising edge of tck
    always_ff @(posedge tck or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_TLR;
        end else begin
            state <= tap_next_state(state, tms);
        end
    end

    // Strobes decoded straight from the state register
    assign capture_ir = (state == ST_CAP_IR);
    assign shift_ir   = (state == ST_SHIFT_IR);
    assign update_ir  = (state == ST_UPD_IR);
    assign capture_dr = (state == ST_CAP_DR);
    assign shift_dr   = (state == ST_SHIFT_DR);
    assign update_dr  = (state == ST_UPD_DR);

    // Five tms ones bring the controller home from anywhere
    a_tms_ones_reach_tlr: assert property (
        @(posedge tck) disable iff (!rst_n)
        tms [*TLR_TMS_ONES] |=> (state == ST_TLR)
    );

endmodule

`default_nettype wire

//--- verilog/tap_shift_reg.sv
// Capture, shift and update register
// Shift stage loads on capture, moves LSB first, and feeds the update stage

`timescale 1ns/100ps
`default_nettype none

module tap_shift_reg #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     tck,
    input  logic     rst_n,
    input  logic     capture,
    input  logic     shift,
    input  logic     update,
    input  logic     tdi,
    input  payload_t capture_val,
    input  payload_t reset_val,
    output logic     tdo,
    output payload_t value
);

    payload_t shift_q;

    // Shift stage, tdi enters at the MSB
    always_ff @(posedge tck) begin
        if (capture) begin
            shift_q <= capture_val;
        end else if (shift) begin
            shift_q <= payload_t'({tdi, shift_q} >> 1);
        end
    end

    assign tdo = shift_q[0];

    // Update stage holds the value seen by the logic
    always_ff @(posedge tck or negedge rst_n) begin
        if (!rst_n) begin
            value <= reset_val;
        end else if (update) begin
            value <= shift_q;
        end
    end

endmodule

`default_nettype wire

//--- verilog/stap.sv
// Slave TAP
// Instruction register, IDCODE and BYPASS behind its own controller

`timescale 1ns/100ps
`default_nettype none

module stap (
    input  logic                   tck,
    input  logic                   rst_n,
    input  logic                   tms,
    input  logic                   tdi,
    input  tap_instr_pkg::idcode_t idcode,
    output logic                   tdo,
    output logic                   tdo_en
);
    import tap_ctrl_pkg::*;
    import tap_instr_pkg::*;

    tap_state_t state;
    logic       capture_ir;
    logic       shift_ir;
    logic       update_ir;
    logic       capture_dr;
    logic       shift_dr;
    logic       tap_rst_n;
    ir_t        ir;
    logic       ir_tdo;
    logic       idcode_tdo;
    logic       sel_idcode;
    logic       bypass_q;
    logic       tdo_next;

    tap_fsm u_tap_fsm (
        .tck        (tck),
        .rst_n      (rst_n),
        .tms        (tms),
        .state      (state),
        .capture_ir (capture_ir),
        .shift_ir   (shift_ir),
        .update_ir  (update_ir),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  ()
    );

    // Low while in Test-Logic-Reset, changes on the falling edge
    always_ff @(negedge tck or negedge rst_n) begin
        if (!rst_n) begin
            tap_rst_n <= 1'b0;
        end else begin
            tap_rst_n <= (state != ST_TLR);
        end
    end

    tap_shift_reg #(.payload_t(ir_t)) u_ir (
        .tck         (tck),
        .rst_n       (tap_rst_n),
        .capture     (capture_ir),
        .shift       (shift_ir),
        .update      (update_ir),
        .tdi         (tdi),
        .capture_val (IR_CAPTURE),
        .reset_val   (OP_IDCODE),
        .tdo         (ir_tdo),
        .value       (ir)
    );

    // Every other opcode, TAPNW_SEL included, falls back to BYPASS
    assign sel_idcode = (ir == OP_IDCODE);

    tap_shift_reg #(.payload_t(idcode_t)) u_idcode (
        .tck         (tck),
        .rst_n       (tap_rst_n),
        .capture     (capture_dr && sel_idcode),
        .shift       (shift_dr && sel_idcode),
        .update      (1'b0),
        .tdi         (tdi),
        .capture_val (idcode),
        .reset_val   ('0),
        .tdo         (idcode_tdo),
        .value       ()
    );

    always_ff @(posedge tck) begin
        if (capture_dr) begin
            bypass_q <= 1'b0;
        end else if (shift_dr) begin
            bypass_q <= tdi;
        end
    end

    always_comb begin
        if (shift_ir) begin
            tdo_next = ir_tdo;
        end else if (sel_idcode) begin
            tdo_next = idcode_tdo;
        end else begin
            tdo_next = bypass_q;
        end
    end

    // Launch on the falling edge for the next stage to sample
    always_ff @(negedge tck or negedge rst_n) begin
        if (!rst_n) begin
            tdo    <= 1'b0;
            tdo_en <= 1'b0;
        end else begin
            tdo_en <= shift_ir | shift_dr;
            if (shift_ir || shift_dr) begin
                tdo <= tdo_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/mtap.sv
// Master TAP
// IR, IDCODE, BYPASS and the select register that enables the slave TAPs

`timescale 1ns/100ps
`default_nettype none

module mtap #(
    parameter int NUM_STAPS = 2
) (
    input  logic                   tck,
    input  logic                   rst_n,
    input  logic                   tms,
    input  logic                   tdi,
    input  tap_instr_pkg::idcode_t idcode,
    output logic                   tdo,
    output logic                   tdo_en,
    output logic [NUM_STAPS-1:0]   enabletap,
    output logic [NUM_STAPS-1:0]   enabletdo
);
    import tap_ctrl_pkg::*;
    import tap_instr_pkg::*;

    typedef logic [NUM_STAPS-1:0] sel_t;

    tap_state_t state;
    logic       capture_ir;
    logic       shift_ir;
    logic       update_ir;
    logic       capture_dr;
    logic       shift_dr;
    logic       update_dr;
    logic       tap_rst_n;
    ir_t        ir;
    logic       ir_tdo;
    logic       idcode_tdo;
    logic       sel_tdo;
    logic       sel_idcode;
    logic       sel_nw;
    logic       bypass_q;
    logic       tdo_next;
    sel_t       sel_q;

    tap_fsm u_tap_fsm (
        .tck        (tck),
        .rst_n      (rst_n),
        .tms        (tms),
        .state      (state),
        .capture_ir (capture_ir),
        .shift_ir   (shift_ir),
        .update_ir  (update_ir),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr)
    );

    // Test-Logic-Reset clears IR and select one half cycle after entry
    always_ff @(negedge tck or negedge rst_n) begin
        if (!rst_n) begin
            tap_rst_n <= 1'b0;
        end else begin
            tap_rst_n <= (state != ST_TLR);
        end
    end

    tap_shift_reg #(.payload_t(ir_t)) u_ir (
        .tck         (tck),
        .rst_n       (tap_rst_n),
        .capture     (capture_ir),
        .shift       (shift_ir),
        .update      (update_ir),
        .tdi         (tdi),
        .capture_val (IR_CAPTURE),
        .reset_val   (OP_IDCODE),
        .tdo         (ir_tdo),
        .value       (ir)
    );

    assign sel_idcode = (ir == OP_IDCODE);
    assign sel_nw     = (ir == OP_TAPNW_SEL);

    tap_shift_reg #(.payload_t(idcode_t)) u_idcode (
        .tck         (tck),
        .rst_n       (tap_rst_n),
        .capture     (capture_dr && sel_idcode),
        .shift       (shift_dr && sel_idcode),
        .update      (1'b0),
        .tdi         (tdi),
        .capture_val (idcode),
        .reset_val   ('0),
        .tdo         (idcode_tdo),
        .value       ()
    );

    // ------------------------------------------------------------------------
    // Network select, one bit per slave, reads back its current value
    // ------------------------------------------------------------------------
    tap_shift_reg #(.payload_t(sel_t)) u_select (
        .tck         (tck),
        .rst_n       (tap_rst_n),
        .capture     (capture_dr && sel_nw),
        .shift       (shift_dr && sel_nw),
        .update      (update_dr && sel_nw),
        .tdi         (tdi),
        .capture_val (sel_q),
        .reset_val   ('0),
        .tdo         (sel_tdo),
        .value       (sel_q)
    );

    assign enabletap = sel_q;
    assign enabletdo = sel_q;

    always_ff @(posedge tck) begin
        if (capture_dr) begin
            bypass_q <= 1'b0;
        end else if (shift_dr) begin
            bypass_q <= tdi;
        end
    end

    always_comb begin
        if (shift_ir) begin
            tdo_next = ir_tdo;
        end else if (sel_idcode) begin
            tdo_next = idcode_tdo;
        end else if (sel_nw) begin
            tdo_next = sel_tdo;
        end else begin
            tdo_next = bypass_q;
        end
    end

    always_ff @(negedge tck or negedge rst_n) begin
        if (!rst_n) begin
            tdo    <= 1'b0;
            tdo_en <= 1'b0;
        end else begin
            tdo_en <= shift_ir | shift_dr;
            if (shift_ir || shift_dr) begin
                tdo <= tdo_next;
            end
        end
    end

    // tdo_en from the last falling edge must match the state held since
    a_tdo_en_in_shift: assert property (
        @(posedge tck) disable iff (!rst_n)
        tdo_en |-> tap_is_shift(state)
    );

endmodule

`default_nettype wire

//--- verilog/tapnw.sv
// TAP network
// Chains enabled slave TAPs behind the master and holds disabled ones in reset

`timescale 1ns/100ps
`default_nettype none

module tapnw #(
    parameter int NUM_STAPS = 2
) (
    input  logic                 rst_n,
    input  logic [NUM_STAPS-1:0] enabletap,
    input  logic [NUM_STAPS-1:0] enabletdo,
    input  logic                 mtap_tdo,
    input  logic                 mtap_tdo_en,
    input  logic [NUM_STAPS-1:0] stap_tdo,
    input  logic [NUM_STAPS-1:0] stap_tdo_en,
    output logic [NUM_STAPS-1:0] stap_tdi,
    output logic [NUM_STAPS-1:0] stap_rst_n,
    output logic                 tdo,
    output logic                 tdo_en
);

    // Stage i feeds slave i, the master sits at stage 0
    logic [NUM_STAPS:0] chain;

    assign chain[0] = mtap_tdo;

    for (genvar i = 0; i < NUM_STAPS; i++) begin : g_stage
        assign stap_tdi[i]   = chain[i];
        // Disabled slave is skipped
        assign chain[i+1]    = enabletdo[i] ? stap_tdo[i] : chain[i];
        assign stap_rst_n[i] = rst_n & enabletap[i];

        // A disabled slave never drives its tdo_en
        always_comb begin
            a_disabled_quiet: assert final (enabletap[i] || !stap_tdo_en[i])
                else $error("disabled slave %0d drives tdo_en", i);
        end
    end

    assign tdo    = chain[NUM_STAPS];
    assign tdo_en = mtap_tdo_en | (|(stap_tdo_en & enabletdo));

endmodule

`default_nettype wire

//--- verilog/tap_chip_top.sv
// TAP chip top level
// Master TAP, TAP network and one slave TAP per network port

`timescale 1ns/100ps
`default_nettype none

module tap_chip_top #(
    parameter int NUM_STAPS = 2
) (
    input  logic                                   tck,
    input  logic                                   rst_n,
    input  logic                                   tms,
    input  logic                                   tdi,
    output logic                                   tdo,
    output logic                                   tdo_en,
    input  tap_instr_pkg::idcode_t                 idcode_mtap,
    input  tap_instr_pkg::idcode_t [NUM_STAPS-1:0] idcode_stap,
    output logic [NUM_STAPS-1:0]                   atap_enabletap,
    output logic [NUM_STAPS-1:0]                   atap_enabletdo
);

    logic                 mtap_tdo;
    logic                 mtap_tdo_en;
    logic [NUM_STAPS-1:0] stap_tdi;
    logic [NUM_STAPS-1:0] stap_rst_n;
    logic [NUM_STAPS-1:0] stap_tdo;
    logic [NUM_STAPS-1:0] stap_tdo_en;

    mtap #(.NUM_STAPS(NUM_STAPS)) u_mtap (
        .tck       (tck),
        .rst_n     (rst_n),
        .tms       (tms),
        .tdi       (tdi),
        .idcode    (idcode_mtap),
        .tdo       (mtap_tdo),
        .tdo_en    (mtap_tdo_en),
        .enabletap (atap_enabletap),
        .enabletdo (atap_enabletdo)
    );

    tapnw #(.NUM_STAPS(NUM_STAPS)) u_tapnw (
        .rst_n       (rst_n),
        .enabletap   (atap_enabletap),
        .enabletdo   (atap_enabletdo),
        .mtap_tdo    (mtap_tdo),
        .mtap_tdo_en (mtap_tdo_en),
        .stap_tdo    (stap_tdo),
        .stap_tdo_en (stap_tdo_en),
        .stap_tdi    (stap_tdi),
        .stap_rst_n  (stap_rst_n),
        .tdo         (tdo),
        .tdo_en      (tdo_en)
    );

    // Slaves share tck and tms, tdi and reset come from the network
    for (genvar i = 0; i < NUM_STAPS; i++) begin : g_stap
        stap u_stap (
            .tck    (tck),
            .rst_n  (stap_rst_n[i]),
            .tms    (tms),
            .tdi    (stap_tdi[i]),
            .idcode (idcode_stap[i]),
            .tdo    (stap_tdo[i]),
            .tdo_en (stap_tdo_en[i])
        );
    end

endmodule

`default_nettype wire

//--- sim/tb_jtag_tasks.svh
// JTAG scan tasks for the TAP chip testbench
// Cycle drive and sample, state walks, and IR or DR scans that start and end in Run-Test/Idle

`ifndef TB_JTAG_TASKS_SVH
`define TB_JTAG_TASKS_SVH

// Drive tms and tdi now, sample tdo just after the next rising edge
task automatic tap_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
    tms = tms_v;
    tdi = tdi_v;
    @(posedge tck);
    #DRIVE_DLY;
    tdo_v = tdo;
endtask

task automatic idle(input int n);
    logic ignored;
    for (int i = 0; i < n; i++) begin
        tap_cycle(1'b0, 1'b0, ignored);
    end
endtask

// Five ones reach Test-Logic-Reset, then step into Run-Test/Idle
task automatic reset_by_tms();
    logic ignored;
    for (int i = 0; i < TLR_TMS_ONES; i++) begin
        tap_cycle(1'b1, 1'b0, ignored);
    end
    tap_cycle(1'b0, 1'b0, ignored);
endtask

// First shift bit, waits for tdo_en from the falling edge
task automatic shift_first_bit(input logic tms_v, input logic tdi_v, output logic tdo_v);
    int cycles;
    cycles = 0;
    tms = tms_v;
    tdi = tdi_v;
    while (tdo_en !== 1'b1 && cycles < WAIT_LIMIT) begin
        @(negedge tck);
        #1;
        cycles++;
    end
    if (tdo_en !== 1'b1) begin
        abort_run("tdo_en never went high after the controller entered a shift state");
    end
    @(posedge tck);
    #DRIVE_DLY;
    tdo_v = tdo;
endtask

task automatic scan(input logic to_ir, input int len, input scan_t din, output scan_t dout);
    logic ignored;
    dout = '0;
    tap_cycle(1'b1, 1'b0, ignored);
    if (to_ir) begin
        tap_cycle(1'b1, 1'b0, ignored);
    end
    // Capture, then enter Shift
    tap_cycle(1'b0, 1'b0, ignored);
    tap_cycle(1'b0, 1'b0, ignored);
    shift_first_bit(len == 1, din[0], dout[0]);
    for (int i = 1; i < len; i++) begin
        tap_cycle(i == len - 1, din[i], dout[i]);
    end
    // Exit1 to Update, then back to idle
    tap_cycle(1'b1, 1'b0, ignored);
    tap_cycle(1'b0, 1'b0, ignored);
endtask

`endif

//--- sim/tb_tap_chip_top.sv
// Testbench for the TAP chip
// Scans IR and DR through the master and the selected slaves and checks every stream

`timescale 1ns/100ps
`default_nettype none

module tb_tap_chip_top;
    import tap_ctrl_pkg::*;
    import tap_instr_pkg::*;

    localparam int NUM_STAPS  = 2;
    localparam int TCK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;
    localparam int WAIT_LIMIT = 4;
    localparam int SCAN_W     = 128;

    typedef logic [NUM_STAPS-1:0] sel_t;
    typedef logic [SCAN_W-1:0]    scan_t;

    logic                    tck;
    logic                    rst_n;
    logic                    tms;
    logic                    tdi;
    logic                    tdo;
    logic                    tdo_en;
    idcode_t                 idcode_mtap;
    idcode_t [NUM_STAPS-1:0] idcode_stap;
    sel_t                    atap_enabletap;
    sel_t                    atap_enabletdo;

    logic [15:0] lfsr_q;
    sel_t        cur_sel;
    int          idcode_errs;
    int          ir_errs;
    int          enable_errs;
    int          stream_errs;
    int          tdo_en_errs;
    int          timeouts;

    tap_chip_top #(.NUM_STAPS(NUM_STAPS)) u_tap_chip_top (
        .tck            (tck),
        .rst_n          (rst_n),
        .tms            (tms),
        .tdi            (tdi),
        .tdo            (tdo),
        .tdo_en         (tdo_en),
        .idcode_mtap    (idcode_mtap),
        .idcode_stap    (idcode_stap),
        .atap_enabletap (atap_enabletap),
        .atap_enabletdo (atap_enabletdo)
    );

    initial begin
        tck = 1'b0;
        forever #(TCK_PERIOD / 2) tck = ~tck;
    end

    task automatic abort_run(input string why);
        $display("Timeout at %0t ns: %s", $time, why);
        timeouts++;
        disable run.main_seq;
    endtask

    `include "tb_jtag_tasks.svh"

    // ------------------------------------------------------------------------
    // Random bits and the chain model
    // ------------------------------------------------------------------------
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic scan_t random_bits(input int n);
        scan_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v[i]   = lfsr_q[0];
        end
        return v;
    endfunction

    function automatic int enabled_count(input sel_t s);
        int n;
        n = 0;
        for (int i = 0; i < NUM_STAPS; i++) begin
            n += s[i];
        end
        return n;
    endfunction

    // Captured chain with the TDO end at bit 0, followed by tdi delayed by the chain
    function automatic scan_t expected_scan(input logic is_ir, input sel_t sel, input ir_t m_ir,
                                            input ir_t s_ir, input scan_t din, output int len);
        scan_t cap;
        cap = '0;
        len = 0;
        for (int i = NUM_STAPS - 1; i >= 0; i--) begin
            if (sel[i] && is_ir) begin
                cap |= scan_t'(IR_CAPTURE) << len;
                len += IR_WIDTH;
            end else if (sel[i] && s_ir == OP_IDCODE) begin
                cap |= scan_t'(idcode_stap[i]) << len;
                len += 32;
            end else if (sel[i]) begin
                len += 1;
            end
        end
        // Master sits next to TDI
        if (is_ir) begin
            cap |= scan_t'(IR_CAPTURE) << len;
            len += IR_WIDTH;
        end else if (m_ir == OP_IDCODE) begin
            cap |= scan_t'(idcode_mtap) << len;
            len += 32;
        end else if (m_ir == OP_TAPNW_SEL) begin
            cap |= scan_t'(sel) << len;
            len += NUM_STAPS;
        end else begin
            len += 1;
        end
        return (din << len) | cap;
    endfunction

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_idcode(input idcode_t got, input idcode_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s IDCODE is %h, expected %h", $time, what, got, exp);
            idcode_errs++;
        end
    endtask

    task automatic check_ir(input ir_t got, input ir_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            ir_errs++;
        end
    endtask

    task automatic check_enables(input sel_t got, input sel_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            enable_errs++;
        end
    endtask

    task automatic check_stream(input scan_t got, input scan_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s stream is %h, expected %h", $time, what, got, exp);
            stream_errs++;
        end
    endtask

    task automatic check_tdo_en(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: tdo_en %s is %b, expected %b", $time, what, got, exp);
            tdo_en_errs++;
        end
    endtask

    task automatic run_scan(input logic is_ir, input ir_t m_ir, input ir_t s_ir,
                            input scan_t din, input int extra, input string what,
                            output scan_t dout);
        scan_t exp;
        scan_t mask;
        int    len;
        exp  = expected_scan(is_ir, cur_sel, m_ir, s_ir, din, len);
        mask = (scan_t'(1) << (len + extra)) - 1;
        scan(is_ir, len + extra, din, dout);
        check_stream(dout & mask, exp & mask, what);
        // Back in Run-Test/Idle, no TAP shifts
        check_tdo_en(tdo_en, 1'b0, {"after ", what});
    endtask

    // Slaves get s_ir, the master gets m_ir in the last nibble shifted
    task automatic load_ir(input ir_t m_ir, input ir_t s_ir);
        scan_t din;
        scan_t dout;
        int    k;
        k   = enabled_count(cur_sel);
        din = '0;
        for (int i = 0; i < k; i++) begin
            din[i*IR_WIDTH +: IR_WIDTH] = s_ir;
        end
        din[k*IR_WIDTH +: IR_WIDTH] = m_ir;
        run_scan(1'b1, m_ir, s_ir, din, 0, "IR scan", dout);
        for (int t = 0; t <= k; t++) begin
            check_ir(dout[t*IR_WIDTH +: IR_WIDTH], IR_CAPTURE, $sformatf("IR capture %0d", t));
        end
    endtask

    task automatic load_select(input sel_t v);
        scan_t dout;
        load_ir(OP_TAPNW_SEL, OP_BYPASS);
        run_scan(1'b0, OP_TAPNW_SEL, OP_BYPASS, scan_t'(v) << enabled_count(cur_sel), 0,
                 "select DR", dout);
        // Newly enabled slaves leave Test-Logic-Reset
        idle(2);
        cur_sel = v;
        check_enables(atap_enabletap, v, "atap_enabletap");
        check_enables(atap_enabletdo, v, "atap_enabletdo");
    endtask

    initial begin : run
        idcode_errs    = 0;
        ir_errs        = 0;
        enable_errs    = 0;
        stream_errs    = 0;
        tdo_en_errs    = 0;
        timeouts       = 0;
        lfsr_q         = 16'd44494;
        cur_sel        = '0;
        rst_n          = 1'b0;
        tms            = 1'b1;
        tdi            = 1'b0;
        idcode_mtap    = 32'h1A2B_3C4D;
        idcode_stap[0] = 32'h0BAD_C0DF;
        idcode_stap[1] = 32'h5EED_1235;

        begin : main_seq
            scan_t dout;
            logic  ignored;
            repeat (5) @(posedge tck);
            #DRIVE_DLY;
            rst_n = 1'b1;
            tap_cycle(1'b0, 1'b0, ignored);

            check_enables(atap_enabletap, '0, "atap_enabletap after reset");
            check_enables(atap_enabletdo, '0, "atap_enabletdo after reset");
            check_tdo_en(tdo_en, 1'b0, "after reset");
            run_scan(1'b0, OP_IDCODE, OP_IDCODE, random_bits(8), 8, "reset IDCODE", dout);
            check_idcode(dout[31:0], idcode_mtap, "master after reset");

            for (int n = 0; n < 6; n++) begin
                load_select(sel_t'(random_bits(NUM_STAPS)));
            end

            // All slaves in the chain, highest index leaves first
            load_select('1);
            load_ir(OP_IDCODE, OP_IDCODE);
            run_scan(1'b0, OP_IDCODE, OP_IDCODE, random_bits(16), 16, "IDCODE chain", dout);
            for (int i = NUM_STAPS - 1; i >= 0; i--) begin
                check_idcode(dout[(NUM_STAPS-1-i)*32 +: 32], idcode_stap[i],
                             $sformatf("slave %0d", i));
            end
            check_idcode(dout[NUM_STAPS*32 +: 32], idcode_mtap, "master in chain");

            load_ir(OP_BYPASS, OP_BYPASS);
            run_scan(1'b0, OP_BYPASS, OP_BYPASS, random_bits(24), 24, "BYPASS delay", dout);

            reset_by_tms();
            cur_sel = '0;
            check_enables(atap_enabletap, '0, "atap_enabletap after tms reset");
            check_enables(atap_enabletdo, '0, "atap_enabletdo after tms reset");
            run_scan(1'b0, OP_IDCODE, OP_IDCODE, random_bits(8), 8, "tms reset IDCODE", dout);
            check_idcode(dout[31:0], idcode_mtap, "master after tms reset");

            load_select('1);
            rst_n = 1'b0;
            idle(3);
            cur_sel = '0;
            check_enables(atap_enabletap, '0, "atap_enabletap in rst_n");
            check_enables(atap_enabletdo, '0, "atap_enabletdo in rst_n");
            rst_n = 1'b1;
            tap_cycle(1'b0, 1'b0, ignored);
            load_ir(OP_IDCODE, OP_IDCODE);
        end

        $display("Errors: idcode %0d, ir %0d, enables %0d, stream %0d, tdo_en %0d, timeouts %0d",
                 idcode_errs, ir_errs, enable_errs, stream_errs, tdo_en_errs, timeouts);
        if (idcode_errs + ir_errs + enable_errs + stream_errs + tdo_en_errs + timeouts == 0)
        begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+sim
verilog/tap_ctrl_pkg.sv
verilog/tap_instr_pkg.sv
verilog/tap_fsm.sv
verilog/tap_shift_reg.sv
verilog/stap.sv
verilog/mtap.sv
verilog/tapnw.sv
verilog/tap_chip_top.sv
sim/tb_tap_chip_top.sv

//--- Bender.yml
package:
  name: tap_chip

sources:
  - files:
      - verilog/tap_ctrl_pkg.sv
      - verilog/tap_instr_pkg.sv
      - verilog/tap_fsm.sv
      - verilog/tap_shift_reg.sv
      - verilog/stap.sv
      - verilog/mtap.sv
      - verilog/tapnw.sv
      - verilog/tap_chip_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_tap_chip_top.sv
